// ==== lsu_pkg.sv ====
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // one strobe bit per byte lane
    localparam int MASK_W = XLEN / 8;

    // access operation as handed over by the pipeline
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8,
        OP_LR_W = 4'd9,
        OP_SC_W = 4'd10,
        OP_AMO  = 4'd11
    } mem_op_e;

    // read-modify-write flavour, only meaningful with OP_AMO
    typedef enum logic [3:0] {
        AMO_SWAP = 4'd0,
        AMO_ADD  = 4'd1,
        AMO_XOR  = 4'd2,
        AMO_AND  = 4'd3,
        AMO_OR   = 4'd4,
        AMO_MIN  = 4'd5,
        AMO_MAX  = 4'd6,
        AMO_MINU = 4'd7,
        AMO_MAXU = 4'd8
    } amo_op_e;

    // timer word offsets from the CLINT timer block base
    localparam logic [XLEN-1:0] MTIMECMP_LO_OFS = 32'h0000_0000;
    localparam logic [XLEN-1:0] MTIMECMP_HI_OFS = 32'h0000_0004;
    localparam logic [XLEN-1:0] MTIME_LO_OFS    = 32'h0000_7ff8;
    localparam logic [XLEN-1:0] MTIME_HI_OFS    = 32'h0000_7ffc;

    // load word seen as byte lanes or halfword lanes
    typedef union packed {
        logic [MASK_W-1:0][7:0] bytes;
        logic [1:0][15:0]       halves;
    } lsu_word_u;

endpackage

// ==== lsu_store_align.sv ====
`timescale 1ns/1ps

module lsu_store_align (
    input  lsu_pkg::mem_op_e              op_i,
    input  logic [1:0]                    addr_lo_i,
    input  logic [lsu_pkg::XLEN-1:0]      data_i,
    output logic [lsu_pkg::MASK_W-1:0]    mask_o,
    output logic [lsu_pkg::XLEN-1:0]      data_o
);
    import lsu_pkg::*;

    // unshifted lane pattern for the access width
    logic [MASK_W-1:0] base_mask;
    // word sized accesses keep lane 0 alignment
    logic              full_word;

    always_comb begin
        full_word = 1'b0;
        case (op_i)
            OP_LB, OP_LBU, OP_SB: base_mask = 4'b0001;
            OP_LH, OP_LHU, OP_SH: base_mask = 4'b0011;
            OP_LW, OP_SW, OP_LR_W, OP_SC_W, OP_AMO: begin
                base_mask = 4'b1111;
                full_word = 1'b1;
            end
            default: base_mask = 4'b0000;
        endcase
    end

    // byte and half land on the addressed lanes
    assign mask_o = full_word ? base_mask : base_mask << addr_lo_i;
    assign data_o = full_word ? data_i : data_i << {addr_lo_i, 3'b000};

    // every real access must strobe at least one lane
    always_comb begin
        if (op_i != OP_NONE) begin
            assert #0 (mask_o != '0)
                else $error("store_align: empty byte mask for op %0d", op_i);
        end
    end

endmodule

// ==== lsu_load_extend.sv ====
`timescale 1ns/1ps

module lsu_load_extend (
    input  lsu_pkg::mem_op_e          op_i,
    input  logic [1:0]                addr_lo_i,
    input  logic [lsu_pkg::XLEN-1:0]  data_i,
    output logic [lsu_pkg::XLEN-1:0]  data_o
);
    import lsu_pkg::*;

    lsu_word_u   word;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign word = data_i;

    // addressed lane, halfword picked by bit 1 only
    assign byte_sel = word.bytes[addr_lo_i];
    assign half_sel = word.halves[addr_lo_i[1]];

    always_comb begin
        case (op_i)
            // signed narrow loads
            OP_LB:   data_o = {{(XLEN-8){byte_sel[7]}}, byte_sel};
            OP_LH:   data_o = {{(XLEN-16){half_sel[15]}}, half_sel};
            // unsigned narrow loads
            OP_LBU:  data_o = {{(XLEN-8){1'b0}}, byte_sel};
            OP_LHU:  data_o = {{(XLEN-16){1'b0}}, half_sel};
            // lw, lr and amo read the full word
            default: data_o = data_i;
        endcase
    end

endmodule

// ==== lsu_amo_alu.sv ====
`timescale 1ns/1ps

module lsu_amo_alu (
    input  lsu_pkg::amo_op_e          amo_op_i,
    input  logic [lsu_pkg::XLEN-1:0]  mem_i,
    input  logic [lsu_pkg::XLEN-1:0]  rs2_i,
    output logic [lsu_pkg::XLEN-1:0]  result_o
);
    import lsu_pkg::*;

    logic signs_differ;
    logic lt_s;
    logic gt_s;
    logic lt_u;
    logic gt_u;

    // signed compare from sign bits and the low 31 bits
    assign signs_differ = mem_i[XLEN-1] ^ rs2_i[XLEN-1];
    // with equal signs the low bits order the same way
    assign lt_s = signs_differ ? mem_i[XLEN-1] : (mem_i[XLEN-2:0] < rs2_i[XLEN-2:0]);
    assign gt_s = signs_differ ? rs2_i[XLEN-1] : (mem_i[XLEN-2:0] > rs2_i[XLEN-2:0]);

    assign lt_u = mem_i < rs2_i;
    assign gt_u = mem_i > rs2_i;

    // new memory word
    always_comb begin
        case (amo_op_i)
            AMO_SWAP: result_o = rs2_i;
            AMO_ADD:  result_o = mem_i + rs2_i;
            AMO_XOR:  result_o = mem_i ^ rs2_i;
            AMO_AND:  result_o = mem_i & rs2_i;
            AMO_OR:   result_o = mem_i | rs2_i;
            AMO_MIN:  result_o = lt_s ? mem_i : rs2_i;
            AMO_MAX:  result_o = gt_s ? mem_i : rs2_i;
            AMO_MINU: result_o = lt_u ? mem_i : rs2_i;
            AMO_MAXU: result_o = gt_u ? mem_i : rs2_i;
            default:  result_o = rs2_i;
        endcase
    end

endmodule

// ==== lsu_seq.sv ====
`timescale 1ns/1ps

module lsu_seq #(
    parameter logic [lsu_pkg::XLEN-1:0] CLINT_BASE = 32'h0200_4000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  lsu_pkg::mem_op_e              req_op_i,
    input  lsu_pkg::amo_op_e              req_amo_op_i,
    input  logic [lsu_pkg::XLEN-1:0]      req_addr_i,
    input  logic [lsu_pkg::XLEN-1:0]      req_wdata_i,
    output logic                          resp_valid_o,
    input  logic                          resp_ready_i,
    output logic [lsu_pkg::XLEN-1:0]      resp_data_o,
    output logic                          resp_fault_o,
    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output logic [lsu_pkg::XLEN-1:0]      mem_addr_o,
    output logic                          mem_we_o,
    output logic [lsu_pkg::MASK_W-1:0]    mem_mask_o,
    output logic [lsu_pkg::XLEN-1:0]      mem_wdata_o,
    input  logic                          mem_resp_valid_i,
    input  logic [lsu_pkg::XLEN-1:0]      mem_rdata_i,
    output logic                          clint_valid_o,
    output logic                          clint_we_o,
    output logic [lsu_pkg::XLEN-1:0]      clint_addr_o,
    output logic [lsu_pkg::XLEN-1:0]      clint_wdata_o,
    input  logic [lsu_pkg::XLEN-1:0]      clint_rdata_i,
    output lsu_pkg::mem_op_e              op_o,
    output lsu_pkg::amo_op_e              amo_op_o,
    output logic [lsu_pkg::XLEN-1:0]      addr_o,
    output logic [lsu_pkg::XLEN-1:0]      wdata_o,
    output logic [lsu_pkg::XLEN-1:0]      loaded_o,
    input  logic [lsu_pkg::MASK_W-1:0]    mask_i,
    input  logic [lsu_pkg::XLEN-1:0]      lane_wdata_i,
    input  logic [lsu_pkg::XLEN-1:0]      load_data_i,
    input  logic [lsu_pkg::XLEN-1:0]      amo_result_i
);
    import lsu_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RD   = 2'd1;
    localparam logic [1:0] ST_WR   = 2'd2;
    localparam logic [1:0] ST_RESP = 2'd3;

    localparam logic [XLEN-1:0] MTIME_LO_ADDR    = CLINT_BASE + MTIME_LO_OFS;
    localparam logic [XLEN-1:0] MTIME_HI_ADDR    = CLINT_BASE + MTIME_HI_OFS;
    localparam logic [XLEN-1:0] MTIMECMP_LO_ADDR = CLINT_BASE + MTIMECMP_LO_OFS;
    localparam logic [XLEN-1:0] MTIMECMP_HI_ADDR = CLINT_BASE + MTIMECMP_HI_OFS;

    logic [1:0]      state_q;
    // memory request of the current phase already taken
    logic            sent_q;
    mem_op_e         op_q;
    amo_op_e         amo_op_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] wdata_q;
    logic [XLEN-1:0] loaded_q;
    logic [XLEN-1:0] resp_data_q;
    logic            resp_fault_q;
    logic            resv_valid_q;
    logic [XLEN-1:0] resv_addr_q;

    logic accept;
    logic in_load;
    logic in_store;
    logic in_lr;
    logic in_sc;
    logic in_amo;
    logic in_atomic;
    logic in_timer;
    logic in_clint;
    logic in_misal;
    logic in_sc_ok;
    logic mem_done;
    logic skip_mem;

    assign accept = req_valid_i & req_ready_o;

    // decode of the incoming request, routing is fixed at acceptance
    assign in_load   = req_op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign in_store  = req_op_i inside {OP_SB, OP_SH, OP_SW};
    assign in_lr     = req_op_i == OP_LR_W;
    assign in_sc     = req_op_i == OP_SC_W;
    assign in_amo    = req_op_i == OP_AMO;
    assign in_atomic = in_lr | in_sc | in_amo;
    assign in_timer  = (req_addr_i == MTIME_LO_ADDR) | (req_addr_i == MTIME_HI_ADDR) |
                       (req_addr_i == MTIMECMP_LO_ADDR) | (req_addr_i == MTIMECMP_HI_ADDR);
    // atomics never reach the timer
    assign in_clint  = in_timer & (in_load | in_store);
    assign in_misal  = in_atomic & (req_addr_i[1:0] != 2'b00);
    assign in_sc_ok  = resv_valid_q & (resv_addr_q == req_addr_i);

    // answered without any memory phase
    assign skip_mem = in_misal | (in_sc & ~in_sc_ok) | in_clint | ~(in_load | in_store | in_atomic);

    assign mem_done = sent_q & mem_resp_valid_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            sent_q  <= 1'b0;
            op_q    <= OP_NONE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        op_q   <= req_op_i;
                        sent_q <= 1'b0;
                        if (skip_mem) begin
                            state_q <= ST_RESP;
                        end else if (in_store | in_sc) begin
                            state_q <= ST_WR;
                        end else begin
                            state_q <= ST_RD;
                        end
                    end
                end
                ST_RD: begin
                    if (mem_req_valid_o & mem_req_ready_i) begin
                        sent_q <= 1'b1;
                    end else if (mem_done) begin
                        sent_q  <= 1'b0;
                        // amo follows its read with the write back
                        state_q <= (op_q == OP_AMO) ? ST_WR : ST_RESP;
                    end
                end
                ST_WR: begin
                    if (mem_req_valid_o & mem_req_ready_i) begin
                        sent_q <= 1'b1;
                    end else if (mem_done) begin
                        sent_q  <= 1'b0;
                        state_q <= ST_RESP;
                    end
                end
                default: begin
                    if (resp_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // reservation flag, lr sets, sc and plain stores clear, amo leaves it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resv_valid_q <= 1'b0;
        end else if (accept & ~in_misal) begin
            if (in_lr) begin
                resv_valid_q <= 1'b1;
            end else if (in_sc | in_store) begin
                resv_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            amo_op_q     <= req_amo_op_i;
            addr_q       <= req_addr_i;
            wdata_q      <= req_wdata_i;
            resp_fault_q <= in_misal;
            // early response value, memory phases may overwrite it
            if (in_misal) begin
                resp_data_q <= '0;
            end else if (in_sc) begin
                resp_data_q <= in_sc_ok ? '0 : XLEN'(1);
            end else if (in_clint & in_load) begin
                // timer words are read whole
                resp_data_q <= clint_rdata_i;
            end else begin
                resp_data_q <= '0;
            end
        end else if (mem_done && state_q == ST_RD) begin
            // extended load data, the old word for lr and amo
            loaded_q    <= mem_rdata_i;
            resp_data_q <= load_data_i;
        end
        if (accept & in_lr & ~in_misal) begin
            resv_addr_q <= req_addr_i;
        end
    end

    assign req_ready_o  = state_q == ST_IDLE;
    assign resp_valid_o = state_q == ST_RESP;
    assign resp_data_o  = resp_data_q;
    assign resp_fault_o = resp_fault_q;

    // one request per phase, dropped once taken
    assign mem_req_valid_o = ((state_q == ST_RD) | (state_q == ST_WR)) & ~sent_q;
    assign mem_addr_o      = addr_q;
    assign mem_we_o        = state_q == ST_WR;
    assign mem_mask_o      = mask_i;
    assign mem_wdata_o     = (op_q == OP_AMO) ? amo_result_i : lane_wdata_i;

    // timer access happens in the accept cycle itself
    assign clint_valid_o = accept & in_clint;
    assign clint_we_o    = in_store;
    assign clint_addr_o  = req_addr_i;
    assign clint_wdata_o = req_wdata_i;

    assign op_o     = op_q;
    assign amo_op_o = amo_op_q;
    assign addr_o   = addr_q;
    assign wdata_o  = wdata_q;
    assign loaded_o = loaded_q;

    a_mem_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_addr_o) &&
        $stable(mem_we_o) && $stable(mem_mask_o) && $stable(mem_wdata_o))
        else $error("seq: memory request changed before ready");

    a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && mem_req_ready_i |=> !mem_req_valid_o until_with mem_resp_valid_i)
        else $error("seq: second memory request before response");

    // stalled response keeps its value and blocks new requests
    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && !req_ready_o &&
        $stable(resp_data_o) && $stable(resp_fault_o))
        else $error("seq: response changed or dropped before accepted");

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
    parameter logic [lsu_pkg::XLEN-1:0] CLINT_BASE = 32'h0200_4000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  lsu_pkg::mem_op_e              req_op_i,
    input  lsu_pkg::amo_op_e              req_amo_op_i,
    input  logic [lsu_pkg::XLEN-1:0]      req_addr_i,
    input  logic [lsu_pkg::XLEN-1:0]      req_wdata_i,
    output logic                          resp_valid_o,
    input  logic                          resp_ready_i,
    output logic [lsu_pkg::XLEN-1:0]      resp_data_o,
    output logic                          resp_fault_o,
    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output logic [lsu_pkg::XLEN-1:0]      mem_addr_o,
    output logic                          mem_we_o,
    output logic [lsu_pkg::MASK_W-1:0]    mem_mask_o,
    output logic [lsu_pkg::XLEN-1:0]      mem_wdata_o,
    input  logic                          mem_resp_valid_i,
    input  logic [lsu_pkg::XLEN-1:0]      mem_rdata_i,
    output logic                          clint_valid_o,
    output logic                          clint_we_o,
    output logic [lsu_pkg::XLEN-1:0]      clint_addr_o,
    output logic [lsu_pkg::XLEN-1:0]      clint_wdata_o,
    input  logic [lsu_pkg::XLEN-1:0]      clint_rdata_i
);
    import lsu_pkg::*;

    // latched request as seen by the lane helpers
    mem_op_e           seq_op;
    amo_op_e           seq_amo_op;
    logic [XLEN-1:0]   seq_addr;
    logic [XLEN-1:0]   seq_wdata;
    logic [XLEN-1:0]   seq_loaded;
    // helper results back into the sequencer
    logic [MASK_W-1:0] lane_mask;
    logic [XLEN-1:0]   lane_wdata;
    logic [XLEN-1:0]   load_data;
    logic [XLEN-1:0]   amo_result;

    lsu_seq #(
        .CLINT_BASE (CLINT_BASE)
    ) u_seq (
        .clk              (clk),
        .rst              (rst),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_op_i         (req_op_i),
        .req_amo_op_i     (req_amo_op_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .resp_valid_o     (resp_valid_o),
        .resp_ready_i     (resp_ready_i),
        .resp_data_o      (resp_data_o),
        .resp_fault_o     (resp_fault_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_addr_o       (mem_addr_o),
        .mem_we_o         (mem_we_o),
        .mem_mask_o       (mem_mask_o),
        .mem_wdata_o      (mem_wdata_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_rdata_i      (mem_rdata_i),
        .clint_valid_o    (clint_valid_o),
        .clint_we_o       (clint_we_o),
        .clint_addr_o     (clint_addr_o),
        .clint_wdata_o    (clint_wdata_o),
        .clint_rdata_i    (clint_rdata_i),
        .op_o             (seq_op),
        .amo_op_o         (seq_amo_op),
        .addr_o           (seq_addr),
        .wdata_o          (seq_wdata),
        .loaded_o         (seq_loaded),
        .mask_i           (lane_mask),
        .lane_wdata_i     (lane_wdata),
        .load_data_i      (load_data),
        .amo_result_i     (amo_result)
    );

    // byte strobes and store lane placement
    lsu_store_align u_store_align (
        .op_i      (seq_op),
        .addr_lo_i (seq_addr[1:0]),
        .data_i    (seq_wdata),
        .mask_o    (lane_mask),
        .data_o    (lane_wdata)
    );

    // raw memory word straight from the read port
    lsu_load_extend u_load_extend (
        .op_i      (seq_op),
        .addr_lo_i (seq_addr[1:0]),
        .data_i    (mem_rdata_i),
        .data_o    (load_data)
    );

    // old word and rs2 give the amo write back value
    lsu_amo_alu u_amo_alu (
        .amo_op_i (seq_amo_op),
        .mem_i    (seq_loaded),
        .rs2_i    (seq_wdata),
        .result_o (amo_result)
    );

endmodule

// ==== tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu;
    import lsu_pkg::*;

    localparam logic [XLEN-1:0] CLINT_BASE = 32'h0200_4000;
    localparam int CLK_PERIOD = 8;
    // request counts per test, the watchdog scales with their sum
    localparam int N_LOAD  = 40;
    localparam int N_STORE = 40;
    localparam int N_CLINT = 16;
    localparam int N_SC    = 14;
    localparam int N_AMO   = 54;
    localparam int N_MISAL = 12;
    localparam int N_REQ   = N_LOAD + N_STORE + N_CLINT + N_SC + N_AMO + N_MISAL;

    logic clk = 1'b0;
    logic rst;
    logic req_valid_i, req_ready_o, resp_valid_o, resp_ready_i, resp_fault_o;
    mem_op_e req_op_i;
    amo_op_e req_amo_op_i;
    logic [XLEN-1:0] req_addr_i, req_wdata_i, resp_data_o;
    logic mem_req_valid_o, mem_req_ready_i, mem_we_o, mem_resp_valid_i;
    logic [XLEN-1:0] mem_addr_o, mem_wdata_o, mem_rdata_i;
    logic [MASK_W-1:0] mem_mask_o;
    logic clint_valid_o, clint_we_o;
    logic [XLEN-1:0] clint_addr_o, clint_wdata_o, clint_rdata_i;

    // memory and timer models plus their shadow copies
    logic [XLEN-1:0] mem [256];
    logic [XLEN-1:0] sh_mem [256];
    logic [XLEN-1:0] timer [4];
    logic [XLEN-1:0] sh_timer [4];
    logic sh_resv_v;
    logic [XLEN-1:0] sh_resv_a;

    logic [31:0] rng = 32'h4b9f_5fd2;
    int err_cnt = 0;
    int chk_cnt = 0;
    int issued = 0;
    int resp_cnt = 0;
    int mem_req_cnt = 0;
    int clint_cnt = 0;
    // memory model response timing
    logic pending = 1'b0;
    int wait_cnt = 0;
    logic [XLEN-1:0] rd_word;
    logic hs;

    // expected responses in request order
    logic [XLEN-1:0] exp_data_q[$];
    logic exp_fault_q[$];
    int exp_nmem_q[$];
    int exp_nclint_q[$];

    lsu_top #(.CLINT_BASE(CLINT_BASE)) DUT (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] rand_word();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // which timer word an address hits, -1 for none
    function automatic int timer_index(logic [XLEN-1:0] addr);
        if (addr == CLINT_BASE + MTIMECMP_LO_OFS) return 0;
        if (addr == CLINT_BASE + MTIMECMP_HI_OFS) return 1;
        if (addr == CLINT_BASE + MTIME_LO_OFS) return 2;
        if (addr == CLINT_BASE + MTIME_HI_OFS) return 3;
        return -1;
    endfunction

    task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // expected result of one request, updates the shadow state
    function automatic void ref_model(input mem_op_e op, input amo_op_e amo,
                                      input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wd,
                                      output logic [XLEN-1:0] data, output logic fault,
                                      output int nmem, output int nclint);
        int ti;
        int off;
        logic [7:0] idx;
        logic [XLEN-1:0] w;
        logic [7:0] b;
        logic [15:0] h;
        ti = timer_index(addr);
        off = addr[1:0];
        idx = addr[9:2];
        w = sh_mem[idx];
        b = w[8*off +: 8];
        h = addr[1] ? w[31:16] : w[15:0];
        data = '0;
        fault = 1'b0;
        nmem = 0;
        nclint = 0;
        if (op inside {OP_LR_W, OP_SC_W, OP_AMO} && off != 0) begin
            // misaligned atomic has no side effect at all
            fault = 1'b1;
        end else if (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW} && ti >= 0) begin
            data = sh_timer[ti];
            nclint = 1;
        end else if (op inside {OP_SB, OP_SH, OP_SW} && ti >= 0) begin
            sh_timer[ti] = wd;
            sh_resv_v = 1'b0;
            nclint = 1;
        end else begin
            nmem = 1;
            case (op)
                OP_LB:  data = {{24{b[7]}}, b};
                OP_LBU: data = {24'h0, b};
                OP_LH:  data = {{16{h[15]}}, h};
                OP_LHU: data = {16'h0, h};
                OP_LW:  data = w;
                OP_SB: begin
                    sh_mem[idx][8*off +: 8] = wd[7:0];
                    sh_resv_v = 1'b0;
                end
                OP_SH: begin
                    sh_mem[idx][8*off +: 16] = wd[15:0];
                    sh_resv_v = 1'b0;
                end
                OP_SW: begin
                    sh_mem[idx] = wd;
                    sh_resv_v = 1'b0;
                end
                OP_LR_W: begin
                    data = w;
                    sh_resv_v = 1'b1;
                    sh_resv_a = addr;
                end
                OP_SC_W: begin
                    if (sh_resv_v && sh_resv_a == addr) begin
                        sh_mem[idx] = wd;
                    end else begin
                        data = 1;
                        nmem = 0;
                    end
                    sh_resv_v = 1'b0;
                end
                OP_AMO: begin
                    data = w;
                    nmem = 2;
                    case (amo)
                        AMO_SWAP: sh_mem[idx] = wd;
                        AMO_ADD:  sh_mem[idx] = w + wd;
                        AMO_XOR:  sh_mem[idx] = w ^ wd;
                        AMO_AND:  sh_mem[idx] = w & wd;
                        AMO_OR:   sh_mem[idx] = w | wd;
                        AMO_MIN:  sh_mem[idx] = ($signed(w) < $signed(wd)) ? w : wd;
                        AMO_MAX:  sh_mem[idx] = ($signed(w) > $signed(wd)) ? w : wd;
                        AMO_MINU: sh_mem[idx] = (w < wd) ? w : wd;
                        default:  sh_mem[idx] = (w > wd) ? w : wd;
                    endcase
                end
                default: nmem = 0;
            endcase
        end
    endfunction

    // memory model, random ready stalls and 0 to 3 cycles of delay
    always @(posedge clk) begin
        hs = !rst && mem_req_valid_o && mem_req_ready_i;
        #1;
        mem_resp_valid_i = 1'b0;
        if (hs) begin
            mem_req_cnt++;
            rd_word = mem[mem_addr_o[9:2]];
            if (mem_we_o) begin
                for (int i = 0; i < MASK_W; i++) begin
                    if (mem_mask_o[i]) mem[mem_addr_o[9:2]][8*i +: 8] = mem_wdata_o[8*i +: 8];
                end
            end
            pending = 1'b1;
            wait_cnt = rand_word() % 4;
        end else if (pending) begin
            if (wait_cnt == 0) begin
                mem_resp_valid_i = 1'b1;
                mem_rdata_i = rd_word;
                pending = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
        mem_req_ready_i = (rand_word() % 4) != 0;
        resp_ready_i = (rand_word() % 3) != 0;
    end

    // timer model, read in the same cycle
    always_comb begin
        clint_rdata_i = '0;
        if (timer_index(clint_addr_o) >= 0) clint_rdata_i = timer[timer_index(clint_addr_o)];
    end

    always @(posedge clk) begin
        if (!rst && clint_valid_o) begin
            clint_cnt++;
            if (clint_we_o && timer_index(clint_addr_o) >= 0) begin
                timer[timer_index(clint_addr_o)] = clint_wdata_o;
            end
        end
    end

    // compares every accepted response against the queued expectation
    always @(posedge clk) begin
        if (!rst && resp_valid_o && resp_ready_i) begin
            if (exp_data_q.size() == 0) begin
                err_cnt++;
                $display("response at %0t arrived with no request outstanding", $time);
            end else begin
                check_word("resp_data_o", resp_data_o, exp_data_q.pop_front());
                check_flag("resp_fault_o", resp_fault_o, exp_fault_q.pop_front());
                check_word("mem requests", mem_req_cnt, exp_nmem_q.pop_front());
                check_word("clint accesses", clint_cnt, exp_nclint_q.pop_front());
            end
            resp_cnt++;
        end
    end

    // issue one request and wait for its response
    task automatic run_req(mem_op_e op, amo_op_e amo, logic [XLEN-1:0] addr,
                           logic [XLEN-1:0] wd);
        logic [XLEN-1:0] d;
        logic f;
        int nm;
        int nc;
        int ti;
        ref_model(op, amo, addr, wd, d, f, nm, nc);
        exp_data_q.push_back(d);
        exp_fault_q.push_back(f);
        exp_nmem_q.push_back(nm);
        exp_nclint_q.push_back(nc);
        mem_req_cnt = 0;
        clint_cnt = 0;
        issued++;
        req_valid_i = 1'b1;
        req_op_i = op;
        req_amo_op_i = amo;
        req_addr_i = addr;
        req_wdata_i = wd;
        do @(posedge clk); while (!req_ready_o);
        #1;
        req_valid_i = 1'b0;
        while (resp_cnt < issued) @(posedge clk);
        #1;
        check_word("memory word", mem[addr[9:2]], sh_mem[addr[9:2]]);
        ti = timer_index(addr);
        if (ti >= 0) check_word("timer word", timer[ti], sh_timer[ti]);
    endtask

    task automatic report(int num, string name, int err_before);
        $display("test %0d %s done, %0d errors", num, name, err_cnt - err_before);
    endtask

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] v;
        int e0;
        mem_op_e ld_ops[5] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        mem_op_e st_ops[3] = '{OP_SB, OP_SH, OP_SW};
        logic [XLEN-1:0] near[4] = '{CLINT_BASE + 8, CLINT_BASE - 4,
                                     CLINT_BASE + 32'h7ff4, CLINT_BASE + 32'h8000};
        logic [XLEN-1:0] mv[3] = '{32'h8000_0000, 32'hffff_ffff, 32'h0};
        logic [XLEN-1:0] rv[3] = '{32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000};
        rst = 1'b1;
        req_valid_i = 1'b0;
        req_op_i = OP_NONE;
        req_amo_op_i = AMO_SWAP;
        req_addr_i = '0;
        req_wdata_i = '0;
        resp_ready_i = 1'b1;
        mem_req_ready_i = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_rdata_i = '0;
        sh_resv_v = 1'b0;
        sh_resv_a = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i + 1) * 32'h9e37_79b9 ^ {i[7:0], ~i[7:0], 16'h5a3c};
            sh_mem[i] = mem[i];
        end
        for (int i = 0; i < 4; i++) begin
            timer[i] = 32'h1000_0000 * (i + 1) + 32'h55;
            sh_timer[i] = timer[i];
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        e0 = err_cnt;
        for (int i = 0; i < N_LOAD; i++) begin
            a = rand_word() & 32'h3ff;
            if (ld_ops[i % 5] inside {OP_LH, OP_LHU}) a[0] = 1'b0;
            if (ld_ops[i % 5] == OP_LW) a[1:0] = 2'b00;
            run_req(ld_ops[i % 5], AMO_SWAP, a, '0);
        end
        report(1, "narrow and word loads", e0);

        e0 = err_cnt;
        for (int i = 0; i < N_STORE / 2; i++) begin
            a = rand_word() & 32'h3ff;
            if (st_ops[i % 3] == OP_SH) a[0] = 1'b0;
            if (st_ops[i % 3] == OP_SW) a[1:0] = 2'b00;
            run_req(st_ops[i % 3], AMO_SWAP, a, rand_word());
            run_req(OP_LW, AMO_SWAP, {a[31:2], 2'b00}, '0);
        end
        report(2, "stores with read back", e0);

        e0 = err_cnt;
        for (int i = 0; i < 4; i++) begin
            a = CLINT_BASE + ((i < 2) ? 4 * i : MTIME_LO_OFS + 4 * (i - 2));
            run_req(OP_SW, AMO_SWAP, a, rand_word());
            run_req(OP_LW, AMO_SWAP, a, '0);
            run_req(OP_SW, AMO_SWAP, near[i], rand_word());
            run_req(OP_LW, AMO_SWAP, near[i], '0);
        end
        report(3, "timer routing", e0);

        e0 = err_cnt;
        run_req(OP_LR_W, AMO_SWAP, 32'h100, '0);
        run_req(OP_SC_W, AMO_SWAP, 32'h100, 32'hcafe_0001);
        run_req(OP_SC_W, AMO_SWAP, 32'h100, 32'hcafe_0002);
        run_req(OP_LR_W, AMO_SWAP, 32'h100, '0);
        run_req(OP_SC_W, AMO_SWAP, 32'h104, 32'hcafe_0003);
        run_req(OP_LR_W, AMO_SWAP, 32'h100, '0);
        run_req(OP_SB, AMO_SWAP, 32'h201, 32'h77);
        run_req(OP_SC_W, AMO_SWAP, 32'h100, 32'hcafe_0004);
        run_req(OP_LR_W, AMO_SWAP, 32'h100, '0);
        run_req(OP_LR_W, AMO_SWAP, 32'h108, '0);
        run_req(OP_SC_W, AMO_SWAP, 32'h108, 32'hcafe_0005);
        run_req(OP_LW, AMO_SWAP, 32'h108, '0);
        run_req(OP_LR_W, AMO_SWAP, 32'h10c, '0);
        run_req(OP_SC_W, AMO_SWAP, 32'h10c, 32'hcafe_0006);
        report(4, "reservation", e0);

        e0 = err_cnt;
        for (int op = 0; op < 9; op++) begin
            for (int k = 0; k < 3; k++) begin
                a = 32'h300 + 4 * k;
                // extreme pairs for every op, random words mixed in on the last slot
                v = (op % 2 == 1 && k == 2) ? rand_word() : mv[k];
                run_req(OP_SW, AMO_SWAP, a, v);
                run_req(OP_AMO, amo_op_e'(op), a, (op > 4 && k == 2) ? rand_word() : rv[k]);
            end
        end
        report(5, "atomic read-modify-write", e0);

        e0 = err_cnt;
        run_req(OP_LR_W, AMO_SWAP, 32'h140, '0);
        for (int i = 1; i < 4; i++) begin
            run_req(OP_LR_W, AMO_SWAP, 32'h180 + i, '0);
            run_req(OP_SC_W, AMO_SWAP, 32'h140 + i, rand_word());
            run_req(OP_AMO, AMO_ADD, 32'h1c0 + i, rand_word());
        end
        run_req(OP_SC_W, AMO_SWAP, 32'h140, 32'hbeef_0001);
        run_req(OP_AMO, AMO_MAXU, 32'h142, 32'h1);
        report(6, "misaligned atomics", e0);

        repeat (4) @(posedge clk);
        if (exp_data_q.size() != 0 || resp_cnt != issued) begin
            err_cnt++;
            $display("%0d requests issued but %0d responses seen", issued, resp_cnt);
        end
        $display("%0d requests, %0d checks, %0d errors", issued, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        #(N_REQ * 200 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", N_REQ * 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
lsu_pkg.sv
lsu_store_align.sv
lsu_load_extend.sv
lsu_amo_alu.sv
lsu_seq.sv
lsu_top.sv
tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_store_align.sv
  - lsu_load_extend.sv
  - lsu_amo_alu.sv
  - lsu_seq.sv
  - lsu_top.sv
  - target: simulation
    files:
      - tb_lsu.sv
